// File: src/rr_log_settings.svh
`ifndef RR_LOG_SETTINGS_SVH
`define RR_LOG_SETTINGS_SVH

// Number of logging channels, which is also the bitmap width
`define RR_CHANNEL_CNT 3

// Fixed channel data widths, channel 0 first
`define RR_CH0_WIDTH 8
`define RR_CH1_WIDTH 12
`define RR_CH2_WIDTH 20

// Width of one storage word in the log buffer
`define RR_WORD_WIDTH 64

// Log buffer address width, 256 words
`define RR_BUF_ADDR_BITS 8

`endif

// File: src/rr_log_pkg.sv
`default_nettype none

`include "rr_log_settings.svh"

package rr_log_pkg;

  // Channel geometry
  localparam int RR_CHANNEL_CNT = `RR_CHANNEL_CNT;
  localparam int RR_MAX_DATA_WIDTH = `RR_CH0_WIDTH + `RR_CH1_WIDTH + `RR_CH2_WIDTH;
  // Bitmap in the low bits, then the densest possible data
  localparam int RR_UNIT_WIDTH = RR_CHANNEL_CNT + RR_MAX_DATA_WIDTH;
  localparam int RR_LEN_BITS = $clog2(RR_UNIT_WIDTH + 1);
  // Shortest unit carries only the narrowest channel
  localparam int RR_MIN_UNIT_LEN = RR_CHANNEL_CNT + `RR_CH0_WIDTH;

  // Storage geometry
  localparam int RR_WORD_WIDTH = `RR_WORD_WIDTH;
  localparam int RR_ADDR_BITS = `RR_BUF_ADDR_BITS;
  localparam int RR_BUF_DEPTH = 1 << RR_ADDR_BITS;

  typedef logic [RR_UNIT_WIDTH-1:0] rr_unit_t;
  typedef logic [RR_LEN_BITS-1:0] rr_len_t;
  typedef logic [RR_CHANNEL_CNT-1:0] rr_bitmap_t;
  typedef logic [RR_WORD_WIDTH-1:0] rr_word_t;
  typedef logic [RR_ADDR_BITS-1:0] rr_addr_t;
  // Word count, one bit wider so a full buffer is representable
  typedef logic [RR_ADDR_BITS:0] rr_count_t;

  // Width table indexed by channel
  localparam logic [RR_CHANNEL_CNT-1:0][RR_LEN_BITS-1:0] RR_CHANNEL_WIDTHS = {
    RR_LEN_BITS'(`RR_CH2_WIDTH),
    RR_LEN_BITS'(`RR_CH1_WIDTH),
    RR_LEN_BITS'(`RR_CH0_WIDTH)
  };

  // Bit position of a channel inside the concatenated channel data bus
  function automatic int rr_channel_base(input int ch);
    int base;
    base = 0;
    for (int i = 0; i < ch; i++) begin
      base += int'(RR_CHANNEL_WIDTHS[i]);
    end
    return base;
  endfunction

  // Unit length from the bitmap alone, constant adds only
  function automatic rr_len_t rr_decode_len(input rr_bitmap_t bitmap);
    rr_len_t len;
    len = rr_len_t'(RR_CHANNEL_CNT);
    for (int i = 0; i < RR_CHANNEL_CNT; i++) begin
      if (bitmap[i]) begin
        len += RR_CHANNEL_WIDTHS[i];
      end
    end
    return len;
  endfunction

endpackage

`default_nettype wire

// File: src/rr_channel_stage.sv
`timescale 1ns/1ps
`default_nettype none

// Register stage for one logging channel
// Stages are chained so each one learns where its data lands in the unit
module rr_channel_stage #(
  parameter int WIDTH = 8
) (
  input  wire                   clk,
  input  wire                   reset,
  input  wire                   strobe,
  input  wire [WIDTH-1:0]       data,
  input  wire rr_log_pkg::rr_len_t  offset_in,
  output logic                  valid,
  output rr_log_pkg::rr_len_t   offset_out,
  output rr_log_pkg::rr_unit_t  placed
);

  import rr_log_pkg::*;

  // Held channel data, zero whenever the channel did not strobe
  logic [WIDTH-1:0] data_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid  <= 1'b0;
      data_q <= '0;
    end else begin
      valid  <= strobe;
      // Zero data keeps the OR merge in the packer clean
      data_q <= strobe ? data : '0;
    end
  end

  // Only a valid channel consumes bits in the unit
  assign offset_out = valid ? offset_in + rr_len_t'(WIDTH) : offset_in;

  // Data placed at the running offset of the lower channels
  assign placed = rr_unit_t'(data_q) << offset_in;

  // Running offset stays inside the data field of a unit
  a_offset_in_range: assert property (
    @(posedge clk) disable iff (reset)
    offset_out <= rr_len_t'(RR_MAX_DATA_WIDTH)
  );

endmodule

`default_nettype wire

// File: src/rr_unit_packer.sv
`timescale 1ns/1ps
`default_nettype none

// Merges the placed data of all channel stages into one log unit
// Unit layout from bit 0 is bitmap, then the data of valid channels only
module rr_unit_packer (
  input  wire                        clk,
  input  wire                        reset,
  input  wire rr_log_pkg::rr_bitmap_t stage_valid,
  input  wire rr_log_pkg::rr_unit_t [rr_log_pkg::RR_CHANNEL_CNT-1:0] stage_placed,
  input  wire rr_log_pkg::rr_len_t   data_len,
  output rr_log_pkg::rr_unit_t       unit,
  output rr_log_pkg::rr_len_t        unit_len,
  output logic                       unit_strobe
);

  import rr_log_pkg::*;

  // OR of all placed data vectors
  rr_unit_t merged;
  // Merged data moved above the bitmap with the bitmap inserted
  rr_unit_t unit_next;
  logic     any_valid;

  always_comb begin
    merged = '0;
    // Placed ranges never overlap, so OR is a dense concatenation
    for (int i = 0; i < RR_CHANNEL_CNT; i++) begin
      merged = merged | stage_placed[i];
    end
  end

  assign any_valid = |stage_valid;

  // Top bits shifted out are always zero since data_len <= max width
  assign unit_next = (merged << RR_CHANNEL_CNT) | rr_unit_t'(stage_valid);

  // One strobe for every non-empty cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      unit_strobe <= 1'b0;
    end else begin
      unit_strobe <= any_valid;
    end
  end

  // Payload only loads on a non-empty cycle
  always_ff @(posedge clk) begin
    if (any_valid) begin
      unit     <= unit_next;
      // Bitmap bits count toward the length
      unit_len <= data_len + rr_len_t'(RR_CHANNEL_CNT);
    end
  end

endmodule

`default_nettype wire

// File: src/rr_stream_writer.sv
`timescale 1ns/1ps
`default_nettype none

// Bit-level writer that packs log units end to end into storage words
// Accumulator is two words wide so one unit always fits behind a partial word
module rr_stream_writer (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       unit_strobe,
  input  wire rr_log_pkg::rr_unit_t unit,
  input  wire rr_log_pkg::rr_len_t  unit_len,
  input  wire                       record_finish,
  output logic                      wr_en,
  output rr_log_pkg::rr_addr_t      wr_addr,
  output rr_log_pkg::rr_word_t      wr_data,
  output rr_log_pkg::rr_count_t     words_written,
  output logic                      overflow,
  output logic                      finish_done
);

  import rr_log_pkg::*;

  localparam int ACC_WIDTH = 2 * RR_WORD_WIDTH;
  localparam int FILL_BITS = $clog2(ACC_WIDTH);

  // Bits above fill are kept zero so appending is a plain OR
  logic [ACC_WIDTH-1:0] acc;
  logic [ACC_WIDTH-1:0] acc_app;
  logic [FILL_BITS-1:0] fill;
  logic [FILL_BITS-1:0] fill_app;
  logic                 word_done;
  logic                 buf_full;
  // Delays finish_done behind the flush write
  logic                 finish_q;

  // Append the incoming unit at the current fill position
  assign acc_app  = acc | (ACC_WIDTH'(unit) << fill);
  assign fill_app = fill + FILL_BITS'(unit_len);
  assign word_done = fill_app >= FILL_BITS'(RR_WORD_WIDTH);
  assign buf_full  = words_written == rr_count_t'(RR_BUF_DEPTH);

  always_ff @(posedge clk) begin
    if (reset) begin
      acc           <= '0;
      fill          <= '0;
      wr_en         <= 1'b0;
      words_written <= '0;
      overflow      <= 1'b0;
      finish_q      <= 1'b0;
      finish_done   <= 1'b0;
    end else begin
      wr_en       <= 1'b0;
      finish_q    <= record_finish;
      finish_done <= finish_q;
      if (record_finish) begin
        // Flush wins over a unit in the same cycle
        if (fill != '0) begin
          if (buf_full) begin
            overflow <= 1'b1;
          end else begin
            wr_en         <= 1'b1;
            words_written <= words_written + 1'b1;
          end
        end
        acc  <= '0;
        fill <= '0;
      end else if (unit_strobe) begin
        if (word_done) begin
          // Low word leaves, residue moves down
          acc  <= acc_app >> RR_WORD_WIDTH;
          fill <= fill_app - FILL_BITS'(RR_WORD_WIDTH);
          if (buf_full) begin
            // Whole word dropped, flag is sticky
            overflow <= 1'b1;
          end else begin
            wr_en         <= 1'b1;
            words_written <= words_written + 1'b1;
          end
        end else begin
          acc  <= acc_app;
          fill <= fill_app;
        end
      end
    end
  end

  // Write payload, qualified by wr_en
  always_ff @(posedge clk) begin
    wr_addr <= rr_addr_t'(words_written);
    // Residue above fill is already zero padding
    wr_data <= record_finish ? acc[RR_WORD_WIDTH-1:0] : acc_app[RR_WORD_WIDTH-1:0];
  end

  // A write is only issued while the buffer still had room
  a_no_write_when_full: assert property (
    @(posedge clk) disable iff (reset)
    wr_en |-> $past(words_written) < rr_count_t'(RR_BUF_DEPTH)
  );

endmodule

`default_nettype wire

// File: src/rr_log_buffer.sv
`timescale 1ns/1ps
`default_nettype none

// On-chip log buffer
// Simple dual port, read data registered one cycle after the request
module rr_log_buffer (
  input  wire                       clk,
  input  wire                       wr_en,
  input  wire rr_log_pkg::rr_addr_t wr_addr,
  input  wire rr_log_pkg::rr_word_t wr_data,
  input  wire                       rd_en,
  input  wire rr_log_pkg::rr_addr_t rd_addr,
  output rr_log_pkg::rr_word_t      rd_data
);

  import rr_log_pkg::*;

  // Storage words, written in order by the stream writer
  rr_word_t mem [RR_BUF_DEPTH];

  // Write port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read port, holds the last word when idle
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// File: src/rr_replay_reader.sv
`timescale 1ns/1ps
`default_nettype none

// Replay reader that rebuilds the bit stream and parses units back out
// Unit length comes only from the bitmap in the low bits of the window
module rr_replay_reader (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        replay_start,
  input  wire rr_log_pkg::rr_count_t words_written,
  output logic                       rd_en,
  output rr_log_pkg::rr_addr_t       rd_addr,
  input  wire rr_log_pkg::rr_word_t  rd_data,
  output rr_log_pkg::rr_unit_t       replay_unit,
  output rr_log_pkg::rr_len_t        replay_len,
  output logic                       replay_strobe,
  output logic                       replay_done,
  output logic                       busy
);

  import rr_log_pkg::*;

  localparam int WIN_WIDTH = 2 * RR_WORD_WIDTH;
  localparam int FILL_BITS = $clog2(WIN_WIDTH);

  // Bit window, zero above fill
  logic [WIN_WIDTH-1:0] win;
  logic [WIN_WIDTH-1:0] win_shift;
  logic [WIN_WIDTH-1:0] win_next;
  logic [FILL_BITS-1:0] fill;
  logic [FILL_BITS-1:0] fill_shift;
  logic [FILL_BITS-1:0] fill_next;
  rr_count_t            rd_ptr;
  rr_count_t            word_limit;
  // Read data arrives this cycle
  logic                 pending;
  rr_bitmap_t           bitmap;
  rr_len_t              len;
  logic                 have_bitmap;
  logic                 words_left;
  logic                 emit;
  logic                 stop_now;

  assign bitmap      = win[RR_CHANNEL_CNT-1:0];
  assign len         = rr_decode_len(bitmap);
  assign have_bitmap = fill >= FILL_BITS'(RR_CHANNEL_CNT);
  assign words_left  = rd_ptr < word_limit;

  // Whole unit present in the window
  assign emit = busy && have_bitmap && (bitmap != '0) && (fill >= FILL_BITS'(len));

  // Zero bitmap is padding, otherwise stop once no more bits can come
  assign stop_now = busy && ((have_bitmap && bitmap == '0) ||
                             (!emit && !words_left && !pending));

  // One read in flight at most, and only when the word fits
  assign rd_en   = busy && !stop_now && !pending && words_left &&
                   (fill < FILL_BITS'(RR_WORD_WIDTH));
  assign rd_addr = rr_addr_t'(rd_ptr);

  // Consume the emitted unit first
  assign win_shift  = emit ? win >> len : win;
  assign fill_shift = emit ? fill - FILL_BITS'(len) : fill;

  // Then append an arriving word behind what is left
  assign win_next  = pending ? win_shift | (WIN_WIDTH'(rd_data) << fill_shift) : win_shift;
  assign fill_next = pending ? fill_shift + FILL_BITS'(RR_WORD_WIDTH) : fill_shift;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy          <= 1'b0;
      pending       <= 1'b0;
      win           <= '0;
      fill          <= '0;
      rd_ptr        <= '0;
      word_limit    <= '0;
      replay_strobe <= 1'b0;
      replay_done   <= 1'b0;
    end else begin
      pending       <= rd_en;
      replay_strobe <= emit;
      replay_done   <= stop_now;
      if (!busy) begin
        // Start is only seen when idle
        if (replay_start) begin
          busy       <= 1'b1;
          win        <= '0;
          fill       <= '0;
          rd_ptr     <= '0;
          word_limit <= words_written;
        end
      end else if (stop_now) begin
        busy <= 1'b0;
      end else begin
        win  <= win_next;
        fill <= fill_next;
        if (rd_en) begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
    end
  end

  // Unit payload, masked to its decoded length
  always_ff @(posedge clk) begin
    if (emit) begin
      replay_unit <= win[RR_UNIT_WIDTH-1:0] & ~(rr_unit_t'('1) << len);
      replay_len  <= len;
    end
  end

  // Every replayed unit carries at least one channel
  a_min_len: assert property (
    @(posedge clk) disable iff (reset)
    replay_strobe |-> replay_len >= rr_len_t'(RR_MIN_UNIT_LEN)
  );

endmodule

`default_nettype wire

// File: src/rr_log_top.sv
`timescale 1ns/1ps
`default_nettype none

// Record and replay logging engine
// Record path is stages, packer, writer and buffer, replay reads the buffer back
module rr_log_top (
  input  wire                                          clk,
  input  wire                                          reset,
  input  wire rr_log_pkg::rr_bitmap_t                  ch_strobe,
  input  wire [rr_log_pkg::RR_MAX_DATA_WIDTH-1:0]      ch_data,
  input  wire                                          record_finish,
  output logic                                         finish_done,
  output logic                                         overflow,
  output rr_log_pkg::rr_count_t                        words_written,
  input  wire                                          replay_start,
  output rr_log_pkg::rr_unit_t                         replay_unit,
  output rr_log_pkg::rr_len_t                          replay_len,
  output logic                                         replay_strobe,
  output logic                                         replay_done,
  output logic                                         busy
);

  import rr_log_pkg::*;

  // Offset chain, entry i feeds stage i, last entry is the data length
  rr_len_t [RR_CHANNEL_CNT:0]    offset_chain;
  rr_bitmap_t                    stage_valid;
  rr_unit_t [RR_CHANNEL_CNT-1:0] stage_placed;
  rr_unit_t                      unit;
  rr_len_t                       unit_len;
  logic                          unit_strobe;
  logic                          wr_en;
  rr_addr_t                      wr_addr;
  rr_word_t                      wr_data;
  logic                          rd_en;
  rr_addr_t                      rd_addr;
  rr_word_t                      rd_data;

  // Channel 0 data starts right above the bitmap
  assign offset_chain[0] = '0;

  for (genvar i = 0; i < RR_CHANNEL_CNT; i++) begin : g_stage
    // Channel i sits at its base in the concatenated input bus
    localparam int CH_WIDTH = int'(RR_CHANNEL_WIDTHS[i]);
    localparam int CH_BASE  = rr_channel_base(i);

    rr_channel_stage #(
      .WIDTH(CH_WIDTH)
    ) u_stage (
      .clk       (clk),
      .reset     (reset),
      .strobe    (ch_strobe[i]),
      .data      (ch_data[CH_BASE +: CH_WIDTH]),
      .offset_in (offset_chain[i]),
      .valid     (stage_valid[i]),
      .offset_out(offset_chain[i+1]),
      .placed    (stage_placed[i])
    );
  end

  rr_unit_packer u_packer (
    .clk         (clk),
    .reset       (reset),
    .stage_valid (stage_valid),
    .stage_placed(stage_placed),
    .data_len    (offset_chain[RR_CHANNEL_CNT]),
    .unit        (unit),
    .unit_len    (unit_len),
    .unit_strobe (unit_strobe)
  );

  rr_stream_writer u_writer (
    .clk          (clk),
    .reset        (reset),
    .unit_strobe  (unit_strobe),
    .unit         (unit),
    .unit_len     (unit_len),
    .record_finish(record_finish),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .words_written(words_written),
    .overflow     (overflow),
    .finish_done  (finish_done)
  );

  rr_log_buffer u_buffer (
    .clk    (clk),
    .wr_en  (wr_en),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .rd_en  (rd_en),
    .rd_addr(rd_addr),
    .rd_data(rd_data)
  );

  rr_replay_reader u_reader (
    .clk          (clk),
    .reset        (reset),
    .replay_start (replay_start),
    .words_written(words_written),
    .rd_en        (rd_en),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data),
    .replay_unit  (replay_unit),
    .replay_len   (replay_len),
    .replay_strobe(replay_strobe),
    .replay_done  (replay_done),
    .busy         (busy)
  );

endmodule

`default_nettype wire

// File: testbench/tb_rr_log_tasks.svh
`ifndef TB_RR_LOG_TASKS_SVH
`define TB_RR_LOG_TASKS_SVH

// Xorshift32 step on the shared generator state
function automatic logic [31:0] next_random();
  logic [31:0] x;
  x = rng_state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  rng_state = x;
  return x;
endfunction

// Random data for all channels at once
function automatic logic [DATA_W-1:0] random_data();
  logic [31:0] hi;
  logic [31:0] lo;
  hi = next_random();
  lo = next_random();
  return DATA_W'({hi, lo});
endfunction

// Expected unit, bitmap first, then valid channel data packed densely
function automatic rr_unit_t model_unit(input rr_bitmap_t strobe, input logic [DATA_W-1:0] data);
  rr_unit_t unit;
  int       pos;
  int       base;
  int       ch;
  int       b;
  unit = rr_unit_t'(strobe);
  pos  = `RR_CHANNEL_CNT;
  base = 0;
  for (ch = 0; ch < `RR_CHANNEL_CNT; ch++) begin
    if (strobe[ch]) begin
      for (b = 0; b < CH_WIDTH[ch]; b++) begin
        unit[pos + b] = data[base + b];
      end
      pos += CH_WIDTH[ch];
    end
    // Input bus keeps every channel at a fixed base
    base += CH_WIDTH[ch];
  end
  return unit;
endfunction

// Expected length, channel count plus valid widths
function automatic rr_len_t model_len(input rr_bitmap_t strobe);
  int len;
  int ch;
  len = `RR_CHANNEL_CNT;
  for (ch = 0; ch < `RR_CHANNEL_CNT; ch++) begin
    if (strobe[ch]) begin
      len += CH_WIDTH[ch];
    end
  end
  return rr_len_t'(len);
endfunction

task automatic check_unit(input string name, input rr_unit_t got, input rr_unit_t exp);
  check_total++;
  if (got !== exp) begin
    error_count++;
    $display("ERROR %s: got 0x%h expected 0x%h", name, got, exp);
  end
endtask

task automatic check_len(input string name, input rr_len_t got, input rr_len_t exp);
  check_total++;
  if (got !== exp) begin
    error_count++;
    $display("ERROR %s: got 0x%h expected 0x%h", name, got, exp);
  end
endtask

task automatic check_count(input string name, input rr_count_t got, input rr_count_t exp);
  check_total++;
  if (got !== exp) begin
    error_count++;
    $display("ERROR %s: got 0x%h expected 0x%h", name, got, exp);
  end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
  check_total++;
  if (got !== exp) begin
    error_count++;
    $display("ERROR %s: got 0x%h expected 0x%h", name, got, exp);
  end
endtask

// Reset held for 16 cycles, expected model cleared
task automatic reset_dut();
  @(negedge clk);
  reset         = 1'b1;
  ch_strobe     = '0;
  ch_data       = '0;
  record_finish = 1'b0;
  replay_start  = 1'b0;
  repeat (16) @(negedge clk);
  reset = 1'b0;
  exp_units.delete();
  exp_lens.delete();
endtask

// One record cycle, a non-empty bitmap yields one expected unit
task automatic drive_cycle(input rr_bitmap_t strobe, input logic [DATA_W-1:0] data);
  @(negedge clk);
  ch_strobe = strobe;
  ch_data   = data;
  if (strobe != '0) begin
    exp_units.push_back(model_unit(strobe, data));
    exp_lens.push_back(model_len(strobe));
  end
endtask

task automatic finish_record();
  int cycles;
  @(negedge clk);
  ch_strobe = '0;
  ch_data   = '0;
  // Last unit needs three edges to reach the writer
  repeat (3) @(negedge clk);
  record_finish = 1'b1;
  @(negedge clk);
  record_finish = 1'b0;
  cycles = 0;
  while (finish_done !== 1'b1 && cycles < 8) begin
    @(negedge clk);
    cycles++;
  end
  if (finish_done !== 1'b1) begin
    error_count++;
    $display("No finish_done within 8 cycles of record_finish");
  end
endtask

// Word count is the ceiling of the stream length, capped by the buffer
task automatic verify_record(input logic exp_overflow);
  int total;
  int words;
  total = 0;
  foreach (exp_lens[i]) begin
    total += int'(exp_lens[i]);
  end
  words = (total + WORD_BITS - 1) / WORD_BITS;
  if (words > BUF_WORDS) begin
    words = BUF_WORDS;
  end
  check_count("words_written", words_written, rr_count_t'(words));
  check_flag("overflow", overflow, exp_overflow);
endtask

task automatic pulse_replay_start();
  @(negedge clk);
  replay_start = 1'b1;
  @(negedge clk);
  replay_start = 1'b0;
endtask

task automatic wait_replay_done();
  int cycles;
  int limit;
  // At most one read every two cycles plus parse slack
  limit  = 4 * int'(words_written) + 32;
  cycles = 0;
  while (replay_done !== 1'b1 && cycles < limit) begin
    @(negedge clk);
    cycles++;
  end
  if (replay_done !== 1'b1) begin
    error_count++;
    $display("Replay did not raise replay_done within %0d cycles", limit);
  end
  units_at_done = got_units.size();
  // Quiet window, any unit arriving here is extra
  repeat (8) @(negedge clk);
endtask

// Replayed units from base onward against the model, in order
task automatic compare_replay(input int base_units, input int base_done);
  int got_n;
  int i;
  got_n = got_units.size() - base_units;
  check_count("replay_unit_count", rr_count_t'(got_n), rr_count_t'(exp_units.size()));
  check_count("units_before_done", rr_count_t'(units_at_done - base_units),
              rr_count_t'(exp_units.size()));
  check_count("replay_done_count", rr_count_t'(done_count - base_done), rr_count_t'(1));
  check_flag("busy", busy, 1'b0);
  for (i = 0; i < got_n && i < exp_units.size(); i++) begin
    check_unit($sformatf("replay_unit[%0d]", i), got_units[base_units + i], exp_units[i]);
    check_len($sformatf("replay_len[%0d]", i), got_lens[base_units + i], exp_lens[i]);
  end
endtask

task automatic replay_and_compare();
  int base_units;
  int base_done;
  base_units = got_units.size();
  base_done  = done_count;
  pulse_replay_start();
  wait_replay_done();
  compare_replay(base_units, base_done);
endtask

task automatic finish_and_check();
  finish_record();
  verify_record(1'b0);
  replay_and_compare();
endtask

// Each channel alone, lengths 11, 15 and 23
task automatic test_single_channels();
  reset_dut();
  drive_cycle(3'b001, random_data());
  drive_cycle(3'b010, random_data());
  drive_cycle(3'b100, random_data());
  finish_and_check();
endtask

// Full 43-bit unit with bitmap 7
task automatic test_all_channels();
  reset_dut();
  drive_cycle(3'b111, random_data());
  finish_and_check();
endtask

task automatic test_random_stream();
  logic [31:0] r;
  int          cum;
  int          crossed;
  reset_dut();
  repeat (200) begin
    r = next_random();
    drive_cycle(rr_bitmap_t'(r[2:0]), random_data());
  end
  // Stream must contain units that straddle a word boundary
  cum     = 0;
  crossed = 0;
  foreach (exp_lens[i]) begin
    if ((cum % WORD_BITS) + int'(exp_lens[i]) > WORD_BITS) begin
      crossed++;
    end
    cum += int'(exp_lens[i]);
  end
  if (crossed == 0) begin
    error_count++;
    $display("Random stream produced no unit crossing a word boundary");
  end
  finish_and_check();
endtask

// Padding of 9 bits, 1 bit and none must never replay as a unit
task automatic test_padding();
  reset_dut();
  repeat (5) drive_cycle(3'b001, random_data());
  finish_and_check();
  reset_dut();
  repeat (3) drive_cycle(3'b001, random_data());
  repeat (2) drive_cycle(3'b010, random_data());
  finish_and_check();
  reset_dut();
  drive_cycle(3'b001, random_data());
  repeat (2) drive_cycle(3'b010, random_data());
  drive_cycle(3'b100, random_data());
  finish_and_check();
endtask

task automatic test_overflow();
  int keep;
  int cum;
  reset_dut();
  repeat (400) drive_cycle(3'b111, random_data());
  finish_record();
  verify_record(1'b1);
  // Only units wholly inside the stored words come back
  keep = 0;
  cum  = 0;
  while (keep < exp_lens.size() && cum + int'(exp_lens[keep]) <= BUF_WORDS * WORD_BITS) begin
    cum += int'(exp_lens[keep]);
    keep++;
  end
  while (exp_units.size() > keep) begin
    void'(exp_units.pop_back());
    void'(exp_lens.pop_back());
  end
  replay_and_compare();
endtask

// Second start during a running replay changes nothing
task automatic test_start_while_busy();
  int base_units;
  int base_done;
  reset_dut();
  repeat (20) drive_cycle(3'b111, random_data());
  finish_record();
  verify_record(1'b0);
  base_units = got_units.size();
  base_done  = done_count;
  pulse_replay_start();
  repeat (4) @(negedge clk);
  if (busy !== 1'b1) begin
    error_count++;
    $display("Replay was not busy when the second replay_start was issued");
  end
  pulse_replay_start();
  wait_replay_done();
  compare_replay(base_units, base_done);
endtask

`endif

// File: testbench/tb_rr_log.sv
`timescale 1ns/1ps
`default_nettype none

`include "rr_log_settings.svh"

// Testbench for the record and replay logging engine
// Records directed unit streams, replays them and compares against a bit model
module tb_rr_log;

  import rr_log_pkg::*;

  // Geometry from the shared header macros
  localparam int DATA_W = `RR_CH0_WIDTH + `RR_CH1_WIDTH + `RR_CH2_WIDTH;
  localparam int CH_WIDTH [`RR_CHANNEL_CNT] = '{`RR_CH0_WIDTH, `RR_CH1_WIDTH, `RR_CH2_WIDTH};
  localparam int WORD_BITS = `RR_WORD_WIDTH;
  localparam int BUF_WORDS = 1 << `RR_BUF_ADDR_BITS;

  // Driven unit cycles of each directed test in run order
  localparam int TEST_LEN_SUM = 3 + 1 + 200 + 14 + 400 + 20;
  localparam int WATCHDOG_CYCLES = TEST_LEN_SUM * 20;

  // DUT inputs
  logic              clk;
  logic              reset;
  rr_bitmap_t        ch_strobe;
  logic [DATA_W-1:0] ch_data;
  logic              record_finish;
  logic              replay_start;

  // DUT outputs
  logic              finish_done;
  logic              overflow;
  rr_count_t         words_written;
  rr_unit_t          replay_unit;
  rr_len_t           replay_len;
  logic              replay_strobe;
  logic              replay_done;
  logic              busy;

  // Expected units in record order
  rr_unit_t          exp_units [$];
  rr_len_t           exp_lens [$];
  // Replayed units as collected by the monitor
  rr_unit_t          got_units [$];
  rr_len_t           got_lens [$];
  int                done_count = 0;
  // Replayed unit count at the moment replay_done was seen
  int                units_at_done;
  int                check_total;
  int                error_count;
  logic [31:0]       rng_state;

  rr_log_top u_dut (
    .clk          (clk),
    .reset        (reset),
    .ch_strobe    (ch_strobe),
    .ch_data      (ch_data),
    .record_finish(record_finish),
    .finish_done  (finish_done),
    .overflow     (overflow),
    .words_written(words_written),
    .replay_start (replay_start),
    .replay_unit  (replay_unit),
    .replay_len   (replay_len),
    .replay_strobe(replay_strobe),
    .replay_done  (replay_done),
    .busy         (busy)
  );

  // 10 ns clock
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Replay monitor collects units and counts replay_done strobes
  always @(negedge clk) begin
    if (!reset && replay_strobe === 1'b1) begin
      got_units.push_back(replay_unit);
      got_lens.push_back(replay_len);
    end
    if (!reset && replay_done === 1'b1) begin
      done_count++;
    end
  end

  // Watchdog bounded by the summed test lengths
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: run did not complete within %0d cycles", WATCHDOG_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  `include "tb_rr_log_tasks.svh"

  // Test sequence
  initial begin
    reset         = 1'b1;
    ch_strobe     = '0;
    ch_data       = '0;
    record_finish = 1'b0;
    replay_start  = 1'b0;
    rng_state     = 32'h32bb;
    check_total   = 0;
    error_count   = 0;

    test_single_channels();
    test_all_channels();
    test_random_stream();
    test_padding();
    test_overflow();
    test_start_while_busy();

    $display("Checks run: %0d, errors: %0d", check_total, error_count);
    if (error_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rr_log.f
+incdir+src
+incdir+testbench
src/rr_log_pkg.sv
src/rr_channel_stage.sv
src/rr_unit_packer.sv
src/rr_stream_writer.sv
src/rr_log_buffer.sv
src/rr_replay_reader.sv
src/rr_log_top.sv
testbench/tb_rr_log.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the rr_log testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rr_log -Mdir "$build_dir" -o tb_rr_log -f rr_log.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/tb_rr_log" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "TB FAILED" "$log_file"; then
  echo "Simulation reported a failure"
  exit 1
fi
if ! grep -q "TB PASSED" "$log_file"; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0
